// File: Makefile
VERILATOR  ?= verilator
TOP        ?= adc_test_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
BURST_LEN  ?= 24
FIFO_DEPTH ?= 16
VFLAGS     ?= --binary --timing --assert -j 0
SIM_ARGS   ?= +verilator+error+limit+100
PASS_MSG   := Testbench passed

PARAMS := -GBURST_LEN=$(BURST_LEN) -GFIFO_DEPTH=$(FIFO_DEPTH)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) $(PARAMS) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) $(PARAMS) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
design/adc_test_pkg.sv
design/pattern_if.sv
design/adc_cmd_seq.sv
design/pattern_gen.sv
design/lane_fifo_bank.sv
design/adc_test.sv
test/adc_test_sva.sv
test/adc_test_tb.sv

// File: design/adc_cmd_seq.sv
`timescale 1ns/100ps

module adc_cmd_seq
    import adc_test_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        fs_init,
    input  logic        fs_type,
    input  logic        fs_conf,
    input  logic        fs_conv,

    output logic        fd_init,
    output logic        fd_type,
    output logic        fd_conf,
    output logic        fd_conv,

    output logic [7:0]  device_type,
    output logic [15:0] device_temp,

    pattern_if.seq      pat
);

    seq_state_t  state;
    seq_state_t  next_state;
    logic [11:0] num;  // cycles spent so far in the current work state

    // ************************************************************************
    // state register and next state
    // ************************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = WAIT;
            WAIT: begin
                if (fs_init) begin  // init wins over the other requests
                    next_state = INIT_IDLE;
                end else if (fs_type) begin
                    next_state = TYPE_IDLE;
                end else if (fs_conf) begin
                    next_state = CONF_IDLE;
                end else if (fs_conv) begin
                    next_state = CONV_IDLE;
                end
            end

            INIT_IDLE: next_state = INIT_WORK;
            INIT_WORK: if (num >= NUM_INIT - 12'd1) next_state = INIT_DONE;
            INIT_DONE: if (!fs_init) next_state = WAIT;

            TYPE_IDLE: next_state = TYPE_WORK;
            TYPE_WORK: if (num >= NUM_TYPE - 12'd1) next_state = TYPE_DONE;
            TYPE_DONE: if (!fs_type) next_state = WAIT;

            CONF_IDLE: next_state = CONF_WORK;
            CONF_WORK: if (num >= NUM_CONF - 12'd1) next_state = CONF_DONE;
            CONF_DONE: if (!fs_conf) next_state = WAIT;

            CONV_IDLE: next_state = CONV_WORK;
            CONV_WORK: if (pat.done) next_state = CONV_DONE;  // length set by the generator
            CONV_DONE: if (!fs_conv) next_state = WAIT;

            default: next_state = IDLE;
        endcase
    end

    // ************************************************************************
    // phase counter
    // ************************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            num <= 12'd0;
        end else if (state == INIT_WORK || state == TYPE_WORK || state == CONF_WORK) begin
            num <= num + 12'd1;
        end else begin
            num <= 12'd0;
        end
    end

    // ************************************************************************
    // status registers
    // ************************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            device_type <= 8'h00;
            device_temp <= 16'h0000;
        end else begin
            if (state == TYPE_IDLE) begin
                device_type <= DEVICE_TYPE_ID;
            end
            if (state == CONF_IDLE) begin
                device_temp <= DEVICE_TEMP_VAL;
            end
        end
    end

    // the done levels follow the state directly
    assign fd_init = (state == INIT_DONE);
    assign fd_type = (state == TYPE_DONE);
    assign fd_conf = (state == CONF_DONE);
    assign fd_conv = (state == CONV_DONE);

    assign pat.start = (state == CONV_WORK);

endmodule

// File: design/adc_test.sv
`timescale 1ns/100ps

module adc_test
    import adc_test_pkg::*;
#(
    parameter int BURST_LEN  = 16,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 fs_init,
    input  logic                 fs_type,
    input  logic                 fs_conf,
    input  logic                 fs_conv,

    output logic                 fd_init,
    output logic                 fd_type,
    output logic                 fd_conf,
    output logic                 fd_conv,

    output logic [7:0]           device_type,
    output logic [15:0]          device_temp,

    input  logic [N_LANES-1:0]   fifo_rd_en,
    output logic [8*N_LANES-1:0] fifo_rd_data,
    output logic [N_LANES-1:0]   fifo_empty
);

    // shared by the sequencer, the generator and the FIFO bank
    pattern_if pat ();

    // ************************************************************************
    // command sequencer
    // ************************************************************************

    adc_cmd_seq u_seq (
        .clk         (clk),
        .rst         (rst),
        .fs_init     (fs_init),
        .fs_type     (fs_type),
        .fs_conf     (fs_conf),
        .fs_conv     (fs_conv),
        .fd_init     (fd_init),
        .fd_type     (fd_type),
        .fd_conf     (fd_conf),
        .fd_conv     (fd_conv),
        .device_type (device_type),
        .device_temp (device_temp),
        .pat         (pat.seq)
    );

    // ************************************************************************
    // test pattern source and lane FIFOs
    // ************************************************************************

    pattern_gen #(
        .BURST_LEN (BURST_LEN)
    ) u_gen (
        .clk (clk),
        .rst (rst),
        .pat (pat.gen)
    );

    lane_fifo_bank #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .pat     (pat.fifo),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty)
    );

endmodule

// File: design/adc_test_pkg.sv
package adc_test_pkg;

    // ************************************************************************
    // sequencer states
    // ************************************************************************

    typedef enum logic [7:0] {
        IDLE      = 8'h00,
        WAIT      = 8'h01,
        INIT_IDLE = 8'h10,
        INIT_WORK = 8'h11,
        INIT_DONE = 8'h12,
        TYPE_IDLE = 8'h20,
        TYPE_WORK = 8'h21,
        TYPE_DONE = 8'h22,
        CONF_IDLE = 8'h30,
        CONF_WORK = 8'h31,
        CONF_DONE = 8'h32,
        CONV_IDLE = 8'h40,
        CONV_WORK = 8'h41,
        CONV_DONE = 8'h42
    } seq_state_t;

    // ************************************************************************
    // phase lengths and status values
    // ************************************************************************

    localparam logic [11:0] NUM_INIT = 12'd16;  // cycles spent in INIT_WORK
    localparam logic [11:0] NUM_TYPE = 12'd16;
    localparam logic [11:0] NUM_CONF = 12'd32;

    localparam logic [7:0]  DEVICE_TYPE_ID  = 8'hFF;
    localparam logic [15:0] DEVICE_TEMP_VAL = 16'h73F4;

    // lane 7 takes the top byte of the seed and lane 0 the bottom byte
    localparam logic [63:0] LANE_SEED = 64'h01030507090B0D0F;

    localparam int N_LANES = 8;

endpackage

// File: design/lane_fifo_bank.sv
`timescale 1ns/100ps

module lane_fifo_bank
    import adc_test_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk,
    input  logic                 rst,
    pattern_if.fifo              pat,
    input  logic [N_LANES-1:0]   rd_en,
    output logic [8*N_LANES-1:0] rd_data,
    output logic [N_LANES-1:0]   empty
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW:0] PTR_ONE = 1;

    logic [N_LANES-1:0] lane_full;
    logic [N_LANES-1:0] lane_empty;

    for (genvar i = 0; i < N_LANES; i++) begin : g_lane
        logic [7:0] mem [FIFO_DEPTH];
        logic [AW:0] wr_ptr;  // extra top bit tells full from empty
        logic [AW:0] rd_ptr;
        logic [7:0] dout_q;
        logic do_wr;
        logic do_rd;

        assign lane_empty[i] = (wr_ptr == rd_ptr);
        assign lane_full[i]  = (wr_ptr[AW] != rd_ptr[AW]) &&
                               (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

        assign do_wr = pat.wr_en[i] && !lane_full[i];
        assign do_rd = rd_en[i] && !lane_empty[i];  // pops on empty are dropped

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                if (do_wr) wr_ptr <= wr_ptr + PTR_ONE;
                if (do_rd) rd_ptr <= rd_ptr + PTR_ONE;
            end
        end

        always_ff @(posedge clk) begin
            if (do_wr) mem[wr_ptr[AW-1:0]] <= pat.data[8*i +: 8];
            if (do_rd) dout_q <= mem[rd_ptr[AW-1:0]];  // holds until the next pop
        end

        assign rd_data[8*i +: 8] = dout_q;
    end

    assign pat.full = lane_full;
    assign empty    = lane_empty;

endmodule

// File: design/pattern_gen.sv
`timescale 1ns/100ps

module pattern_gen
    import adc_test_pkg::*;
#(
    parameter int BURST_LEN = 16
) (
    input  logic   clk,
    input  logic   rst,
    pattern_if.gen pat
);

    localparam int CW = $clog2(BURST_LEN + 1);
    localparam logic [CW-1:0] BURST_END = CW'(BURST_LEN);

    logic [7:0]         next_byte [N_LANES];  // byte each lane writes next
    logic [CW-1:0]      burst_cnt [N_LANES];
    logic [N_LANES-1:0] lane_fin;
    logic [N_LANES-1:0] lane_wr;

    // ************************************************************************
    // write enables and lane data
    // ************************************************************************

    always_comb begin
        for (int i = 0; i < N_LANES; i++) begin
            lane_fin[i] = (burst_cnt[i] == BURST_END);
            // a full lane waits while the others keep going
            lane_wr[i] = pat.start && !lane_fin[i] && !pat.full[i];
            pat.data[8*i +: 8] = next_byte[i];
        end
    end

    assign pat.wr_en = lane_wr;
    assign pat.done  = pat.start && (&lane_fin);

    // ************************************************************************
    // per-lane byte and burst counters
    // ************************************************************************

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < N_LANES; i++) begin
                next_byte[i] <= LANE_SEED[8*i +: 8];
                burst_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N_LANES; i++) begin
                // the sequence carries on across conversions
                if (lane_wr[i]) begin
                    next_byte[i] <= next_byte[i] + 8'd1;
                end
                if (!pat.start) begin
                    burst_cnt[i] <= '0;  // ready for the next conversion
                end else if (lane_wr[i]) begin
                    burst_cnt[i] <= burst_cnt[i] + CW'(1);
                end
            end
        end
    end

endmodule

// File: design/pattern_if.sv
`timescale 1ns/100ps

interface pattern_if
    import adc_test_pkg::*;
();

    logic                   start;  // high for the whole conversion window
    logic                   done;   // every lane has written its burst
    logic [8*N_LANES-1:0]   data;   // one byte per lane, lane 7 on top
    logic [N_LANES-1:0]     wr_en;
    logic [N_LANES-1:0]     full;

    modport seq (
        output start,
        input  done
    );

    modport gen (
        input  start,
        output done,
        output data,
        output wr_en,
        input  full
    );

    modport fifo (
        input  data,
        input  wr_en,
        output full
    );

endinterface

// File: test/adc_test_sva.sv
`timescale 1ns/100ps

module adc_test_sva
    import adc_test_pkg::*;
(
    input logic               clk,
    input logic               rst,
    input logic               fs_init,
    input logic               fs_type,
    input logic               fs_conf,
    input logic               fs_conv,
    input logic               fd_init,
    input logic               fd_type,
    input logic               fd_conf,
    input logic               fd_conv,
    input logic [7:0]         device_type,
    input logic [15:0]        device_temp,
    input logic [N_LANES-1:0] fifo_empty,
    input seq_state_t         seq_state
);

    int sva_errors = 0;

    // ************************************************************************
    // reset levels
    // ************************************************************************

    a_reset_levels: assert property (@(posedge clk)
        rst |-> ({fd_init, fd_type, fd_conf, fd_conv} == 4'b0000 && device_type == 8'h00
                 && device_temp == 16'h0000 && &fifo_empty))
        else begin
            sva_errors++;
            $error("outputs left their reset levels");
        end

    a_reset_state: assert property (@(posedge clk)
        $fell(rst) |-> seq_state == IDLE ##1 seq_state == WAIT)
        else begin
            sva_errors++;
            $error("sequencer did not pass IDLE into WAIT");
        end

    // ************************************************************************
    // phase lengths, counted back from the rise of each done level
    // ************************************************************************

    a_init_len: assert property (@(posedge clk) disable iff (rst)
        $rose(fd_init) |-> $past(seq_state, NUM_INIT + 1) == INIT_IDLE)
        else begin
            sva_errors++;
            $error("init phase length wrong");
        end

    a_type_len: assert property (@(posedge clk) disable iff (rst)
        $rose(fd_type) |-> $past(seq_state, NUM_TYPE + 1) == TYPE_IDLE)
        else begin
            sva_errors++;
            $error("type phase length wrong");
        end

    a_conf_len: assert property (@(posedge clk) disable iff (rst)
        $rose(fd_conf) |-> $past(seq_state, NUM_CONF + 1) == CONF_IDLE)
        else begin
            sva_errors++;
            $error("conf phase length wrong");
        end

    // done holds exactly as long as its request is sampled high
    a_init_hold: assert property (@(posedge clk) disable iff (rst)
        fd_init |=> fd_init == $past(fs_init))
        else begin
            sva_errors++;
            $error("fd_init hold broken");
        end

    a_type_hold: assert property (@(posedge clk) disable iff (rst)
        fd_type |=> fd_type == $past(fs_type))
        else begin
            sva_errors++;
            $error("fd_type hold broken");
        end

    a_conf_hold: assert property (@(posedge clk) disable iff (rst)
        fd_conf |=> fd_conf == $past(fs_conf))
        else begin
            sva_errors++;
            $error("fd_conf hold broken");
        end

    a_conv_hold: assert property (@(posedge clk) disable iff (rst)
        fd_conv |=> fd_conv == $past(fs_conv))
        else begin
            sva_errors++;
            $error("fd_conv hold broken");
        end

endmodule

bind adc_test adc_test_sva u_sva (
    .clk         (clk),
    .rst         (rst),
    .fs_init     (fs_init),
    .fs_type     (fs_type),
    .fs_conf     (fs_conf),
    .fs_conv     (fs_conv),
    .fd_init     (fd_init),
    .fd_type     (fd_type),
    .fd_conf     (fd_conf),
    .fd_conv     (fd_conv),
    .device_type (device_type),
    .device_temp (device_temp),
    .fifo_empty  (fifo_empty),
    .seq_state   (u_seq.state)
);

// File: test/adc_test_tb.sv
`timescale 1ns/100ps

module adc_test_tb
    import adc_test_pkg::*;
();

    parameter int BURST_LEN  = 24;  // above FIFO_DEPTH so the lanes back up
    parameter int FIFO_DEPTH = 16;

    localparam int LIMIT = 4000;  // cycles allowed for any single wait

    logic                 clk = 1'b0;
    logic                 rst;
    logic [3:0]           fs;  // init, type, conf, conv from bit 0 up
    logic [3:0]           fd;
    logic [7:0]           device_type;
    logic [15:0]          device_temp;
    logic [N_LANES-1:0]   rd_en = '0;
    logic [8*N_LANES-1:0] rd_data;
    logic [N_LANES-1:0]   empty;

    integer             seed = 56;
    int                 check_errors = 0;
    int                 data_errors = 0;
    int                 timeouts = 0;
    int                 target = 0;  // bytes each lane has delivered once drained
    logic               reading = 1'b0;
    logic [N_LANES-1:0] popped = '0;
    logic [7:0]         exp_byte [N_LANES];
    int                 got [N_LANES];

    always #4 clk = ~clk;

    adc_test #(
        .BURST_LEN  (BURST_LEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uut (
        .clk          (clk),
        .rst          (rst),
        .fs_init      (fs[0]),
        .fs_type      (fs[1]),
        .fs_conf      (fs[2]),
        .fs_conv      (fs[3]),
        .fd_init      (fd[0]),
        .fd_type      (fd[1]),
        .fd_conf      (fd[2]),
        .fd_conv      (fd[3]),
        .device_type  (device_type),
        .device_temp  (device_temp),
        .fifo_rd_en   (rd_en),
        .fifo_rd_data (rd_data),
        .fifo_empty   (empty)
    );

    // ************************************************************************
    // host reader and lane scoreboard
    // ************************************************************************

    // each lane counts up from its seed byte and never restarts after reset
    always @(negedge clk) begin
        for (int i = 0; i < N_LANES; i++) begin
            if (rst) begin
                exp_byte[i] = LANE_SEED[8*i +: 8];
                got[i] <= 0;
            end else if (popped[i]) begin  // byte popped on the last rising edge
                assert (rd_data[8*i +: 8] == exp_byte[i]) else begin
                    data_errors++;
                    $display("error at %0t: lane %0d read %h, expected %h",
                             $time, i, rd_data[8*i +: 8], exp_byte[i]);
                end
                exp_byte[i] = exp_byte[i] + 8'd1;
                got[i] <= got[i] + 1;
            end
            popped[i] = reading && !empty[i] && (($random(seed) & 1) == 0);
        end
        rd_en = popped;
    end

    function automatic logic all_read();
        logic ok;
        ok = 1'b1;
        for (int i = 0; i < N_LANES; i++) begin
            if (got[i] != target) ok = 1'b0;
        end
        return ok;
    endfunction

    // ************************************************************************
    // command phases
    // ************************************************************************

    task automatic run_phase(input logic [1:0] which, input int expected);
        int cycles;
        fs[which] = 1'b1;
        @(posedge clk);  // sampling edge
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            @(negedge clk);
        end while (!fd[which] && cycles < LIMIT);
        if (!fd[which]) begin
            timeouts++;
            $display("timeout: the done level of request %0d never rose", which);
            return;
        end
        assert (cycles == expected) else begin
            check_errors++;
            $display("error at %0t: done %0d rose after %0d cycles, expected %0d",
                     $time, which, cycles, expected);
        end
        repeat (5) begin
            @(negedge clk);
            assert (fd[which]) else begin
                check_errors++;
                $display("error at %0t: done %0d fell while requested", $time, which);
            end
        end
        fs[which] = 1'b0;
        @(negedge clk);
        assert (!fd[which]) else begin
            check_errors++;
            $display("error at %0t: done %0d still high after release", $time, which);
        end
        @(negedge clk);
    endtask

    task automatic run_conv(input logic hold_off);
        int cycles;
        target += BURST_LEN;
        reading <= !hold_off;
        fs[3] = 1'b1;
        if (hold_off) begin
            cycles = 0;
            while (empty != '0 && cycles < LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (empty != '0) begin
                timeouts++;
                $display("timeout: the lane FIFOs never received data");
                return;
            end
            repeat (2 * FIFO_DEPTH) begin
                @(negedge clk);
                if (BURST_LEN > FIFO_DEPTH) begin
                    assert (!fd[3]) else begin
                        check_errors++;
                        $display("error at %0t: fd_conv high with lanes backed up", $time);
                    end
                end
            end
            reading <= 1'b1;
        end
        cycles = 0;
        while (!(fd[3] && all_read()) && cycles < LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!(fd[3] && all_read())) begin
            timeouts++;
            $display("timeout: the conversion did not finish with every lane drained");
            return;
        end
        assert (empty == '1) else begin
            check_errors++;
            $display("error at %0t: FIFOs hold %b extra data", $time, ~empty);
        end
        reading <= 1'b0;
        fs[3] = 1'b0;
        @(negedge clk);
        assert (!fd[3]) else begin
            check_errors++;
            $display("error at %0t: fd_conv still high after release", $time);
        end
        @(negedge clk);
    endtask

    task automatic finish_run();
        int sva_errors;
        sva_errors = uut.u_sva.sva_errors;
        $display("check errors: %0d, data errors: %0d, assertion failures: %0d, timeouts: %0d",
                 check_errors, data_errors, sva_errors, timeouts);
        if (check_errors == 0 && data_errors == 0 && sva_errors == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // ************************************************************************
    // test sequence
    // ************************************************************************

    initial begin
        rst = 1'b1;
        fs = 4'b0000;
        repeat (8) @(posedge clk);
        @(negedge clk);
        assert (fd == 4'b0000 && device_type == 8'h00 && device_temp == 16'h0000
                && empty == '1) else begin
            check_errors++;
            $display("error at %0t: outputs not at their reset levels", $time);
        end
        rst = 1'b0;
        repeat (2) @(negedge clk);  // IDLE then WAIT
        run_phase(2'd0, NUM_INIT + 1);
        if (timeouts == 0) run_phase(2'd1, NUM_TYPE + 1);
        if (timeouts == 0) run_phase(2'd2, NUM_CONF + 1);
        assert (device_type == DEVICE_TYPE_ID && device_temp == DEVICE_TEMP_VAL) else begin
            check_errors++;
            $display("error at %0t: status reads %h / %h", $time, device_type, device_temp);
        end
        if (timeouts == 0) run_conv(1'b0);  // host drains while the lanes fill
        if (timeouts == 0) run_conv(1'b1);  // lanes back up before the host reads
        finish_run();
    end

endmodule
